//--- project.f
cache_geom_pkg.sv
tag_types_pkg.sv
tag_ram.sv
tag_way.sv
nru_victim.sv
tag_dir_top.sv
tag_dir_assert.sv
tb_tag_dir.sv

//--- run.sh
#!/bin/sh
# Build the tag directory testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_tag_dir -f project.f -o sim_tb; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error status"
  exit 1
fi

cat sim.log

if grep -qx "test passed" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- tb_tag_dir.sv
`default_nettype none

module tb_tag_dir
  import cache_geom_pkg::*;
  import tag_types_pkg::*;
();

  localparam int num_rows    = 17;
  localparam int num_rand    = 200;
  localparam int cycle_limit = 3 + num_sets + 3 * num_rows + num_rand + 50;

  localparam logic [index_bits-1:0] dir_set = 6'h05;
  localparam logic [tag_bits-1:0]   tag_a   = 14'h0011;
  localparam logic [tag_bits-1:0]   tag_b   = 14'h0022;
  localparam logic [tag_bits-1:0]   tag_c   = 14'h0033;
  localparam logic [tag_bits-1:0]   tag_d   = 14'h0044;
  localparam logic [tag_bits-1:0]   tag_e   = 14'h0055;

  typedef struct packed {
    tag_op_e              op;
    logic [addr_bits-1:0] addr;
    logic                 hit;
    logic [way_bits-1:0]  way;
    logic                 ev;
    logic [addr_bits-1:0] ev_addr;
  } dir_row_t;

  typedef struct packed {
    tag_req_t req;
    tag_rsp_t rsp;
  } pending_t;

  logic     clk;
  logic     rst;
  logic     req_valid;
  tag_req_t req;
  logic     rsp_valid;
  tag_rsp_t rsp;
  logic     init_busy;

  dir_row_t dir_tab [num_rows];
  int       row_cnt;
  pending_t pend_q [$];
  int       errors;
  int       checks;
  int       tests;
  int       cycles;

  // Reference state per set that starts cleared like the init sweep
  logic                m_valid [num_sets][num_ways];
  logic [tag_bits-1:0] m_tag [num_sets][num_ways];
  nru_bits_t           m_nru [num_sets];

  tag_dir_top u_dut (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .init_busy (init_busy)
  );

  bind tag_dir_top tag_dir_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .init_busy (init_busy),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not complete within %0d cycles", cycle_limit);
    $display("test failed");
    $finish;
  end

  // ####################
  // Reference model
  // ####################

  task automatic touch(input int set, input int w);
    m_nru[set][w] = 1'b1;
    // New round once every way has been used
    if (&m_nru[set]) begin
      m_nru[set]    = '0;
      m_nru[set][w] = 1'b1;
    end
  endtask

  task automatic model_apply(input tag_req_t r, output tag_rsp_t e);
    int                  idx;
    logic [tag_bits-1:0] tg;
    logic                hit;
    int                  hw;
    int                  vic;
    idx = int'(r.line_addr[index_bits-1:0]);
    tg  = r.line_addr[addr_bits-1:index_bits];
    hit = 1'b0;
    hw  = 0;
    vic = -1;
    for (int w = 0; w < num_ways; w++) begin
      if (!hit && m_valid[idx][w] && m_tag[idx][w] == tg) begin
        hit = 1'b1;
        hw  = w;
      end
    end
    for (int w = 0; w < num_ways; w++) begin
      if (vic < 0 && !m_valid[idx][w]) vic = w;
    end
    for (int w = 0; w < num_ways; w++) begin
      if (vic < 0 && !m_nru[idx][w]) vic = w;
    end
    if (vic < 0) vic = 0;
    e     = '0;
    e.hit = hit;
    e.way = way_bits'(hw);
    case (r.op)
      op_lookup: if (hit) touch(idx, hw);
      op_fill: begin
        if (!hit) begin
          e.way         = way_bits'(vic);
          e.evict_valid = m_valid[idx][vic];
          if (m_valid[idx][vic]) begin
            e.evict_addr = {m_tag[idx][vic], r.line_addr[index_bits-1:0]};
          end
          m_valid[idx][vic] = 1'b1;
          m_tag[idx][vic]   = tg;
          touch(idx, vic);
        end
      end
      op_inval: if (hit) m_valid[idx][hw] = 1'b0;
      default: ;
    endcase
  endtask

  // ####################
  // Checking
  // ####################

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] want, input pending_t cur);
    $display("Mismatch %s: got %0h, expected %0h (%s %05h)", sig, got, want,
             cur.req.op.name(), cur.req.line_addr);
    errors++;
  endtask

  task automatic check_rsp();
    pending_t cur;
    assert (pend_q.size() != 0) else begin
      $display("A response arrived with no request outstanding");
      errors++;
    end
    if (pend_q.size() != 0) begin
      cur = pend_q.pop_front();
      checks++;
      assert (rsp.hit == cur.rsp.hit) else
        report_mismatch("rsp.hit", 32'(rsp.hit), 32'(cur.rsp.hit), cur);
      assert (rsp.way == cur.rsp.way) else
        report_mismatch("rsp.way", 32'(rsp.way), 32'(cur.rsp.way), cur);
      assert (rsp.evict_valid == cur.rsp.evict_valid) else
        report_mismatch("rsp.evict_valid", 32'(rsp.evict_valid),
                        32'(cur.rsp.evict_valid), cur);
      assert (rsp.evict_addr == cur.rsp.evict_addr) else
        report_mismatch("rsp.evict_addr", 32'(rsp.evict_addr),
                        32'(cur.rsp.evict_addr), cur);
    end
  endtask

  // Responses are sampled at the falling edge, before new inputs go out
  task automatic tick();
    @(negedge clk);
    if (rsp_valid) check_rsp();
  endtask

  task automatic drain();
    while (pend_q.size() != 0) tick();
  endtask

  task automatic add_row(input tag_op_e op, input logic [addr_bits-1:0] addr,
                         input logic hit, input logic [way_bits-1:0] way,
                         input logic ev, input logic [addr_bits-1:0] ev_addr);
    dir_tab[row_cnt] = '{op, addr, hit, way, ev, ev_addr};
    row_cnt++;
  endtask

  task automatic fill_table();
    row_cnt = 0;
    add_row(op_lookup, {14'h3fff, 6'h3f}, 1'b0, 1'b0, 1'b0, 20'h0);
    add_row(op_lookup, {tag_a, dir_set}, 1'b0, 1'b0, 1'b0, 20'h0);
    add_row(op_fill, {tag_a, dir_set}, 1'b0, 1'b0, 1'b0, 20'h0);
    add_row(op_fill, {tag_b, dir_set}, 1'b0, 1'b1, 1'b0, 20'h0);
    add_row(op_lookup, {tag_a, dir_set}, 1'b1, 1'b0, 1'b0, 20'h0);
    add_row(op_lookup, {tag_b, dir_set}, 1'b1, 1'b1, 1'b0, 20'h0);
    add_row(op_fill, {tag_c, dir_set}, 1'b0, 1'b0, 1'b1, {tag_a, dir_set});
    // Touching B moves the next victim back to way 0
    add_row(op_lookup, {tag_b, dir_set}, 1'b1, 1'b1, 1'b0, 20'h0);
    add_row(op_fill, {tag_d, dir_set}, 1'b0, 1'b0, 1'b1, {tag_c, dir_set});
    add_row(op_fill, {tag_e, dir_set}, 1'b0, 1'b1, 1'b1, {tag_b, dir_set});
    add_row(op_inval, {tag_d, dir_set}, 1'b1, 1'b0, 1'b0, 20'h0);
    add_row(op_lookup, {tag_d, dir_set}, 1'b0, 1'b0, 1'b0, 20'h0);
    add_row(op_fill, {tag_a, dir_set}, 1'b0, 1'b0, 1'b0, 20'h0);
    add_row(op_fill, {tag_e, dir_set}, 1'b1, 1'b1, 1'b0, 20'h0);
    add_row(op_lookup, {tag_e, dir_set}, 1'b1, 1'b1, 1'b0, 20'h0);
    add_row(op_inval, {tag_c, dir_set}, 1'b0, 1'b0, 1'b0, 20'h0);
    add_row(op_lookup, {tag_a, 6'h06}, 1'b0, 1'b0, 1'b0, 20'h0);
  endtask

  // ####################
  // Stimulus
  // ####################

  initial begin : main
    pending_t            p;
    int                  err_before;
    int                  pick;
    int                  total;
    int                  busy_cycles;
    logic [tag_bits-1:0] rand_tag;
    rst       = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    void'($urandom(32'h871a0742));
    for (int s = 0; s < num_sets; s++) begin
      m_nru[s] = '0;
      for (int w = 0; w < num_ways; w++) begin
        m_valid[s][w] = 1'b0;
        m_tag[s][w]   = '0;
      end
    end
    fill_table();
    repeat (3) tick();
    rst = 1'b0;

    // Strobes during the sweep must leave no trace
    err_before    = errors;
    req_valid     = 1'b1;
    req.op        = op_fill;
    req.line_addr = {tag_a, dir_set};
    busy_cycles   = 0;
    while (init_busy) begin
      tick();
      busy_cycles++;
    end
    req_valid = 1'b0;
    assert (busy_cycles == num_sets) else begin
      $display("Mismatch init_busy cycles: got %0h, expected %0h", busy_cycles, num_sets);
      errors++;
    end
    tests++;
    $display("init sweep: %s", (errors == err_before) ? "ok" : "ERROR");

    for (int i = 0; i < num_rows; i++) begin
      err_before    = errors;
      p.req.op      = dir_tab[i].op;
      p.req.line_addr = dir_tab[i].addr;
      p.rsp         = '0;
      p.rsp.hit     = dir_tab[i].hit;
      p.rsp.way     = dir_tab[i].way;
      p.rsp.evict_valid = dir_tab[i].ev;
      p.rsp.evict_addr  = dir_tab[i].ev_addr;
      pend_q.push_back(p);
      req_valid = 1'b1;
      req       = p.req;
      tick();
      req_valid = 1'b0;
      drain();
      tests++;
      $display("row %0d %s %05h: %s", i, p.req.op.name(), p.req.line_addr,
               (errors == err_before) ? "ok" : "ERROR");
    end

    // Two sets, eight tags, one request per cycle
    err_before = errors;
    for (int n = 0; n < num_rand; n++) begin
      pick     = $urandom_range(9);
      rand_tag = 14'h0100 + tag_bits'($urandom_range(7));
      p.req.line_addr = {rand_tag, 6'h09 + index_bits'($urandom_range(1))};
      if (pick < 4) p.req.op = op_lookup;
      else if (pick < 8) p.req.op = op_fill;
      else p.req.op = op_inval;
      model_apply(p.req, p.rsp);
      pend_q.push_back(p);
      req_valid = 1'b1;
      req       = p.req;
      tick();
    end
    req_valid = 1'b0;
    drain();
    tests++;
    $display("random %0d ops: %s", num_rand, (errors == err_before) ? "ok" : "ERROR");

    total = errors + int'(u_dut.u_assert.fail_count);
    $display("Summary: %0d tests, %0d responses checked, %0d errors", tests, checks, total);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tag_dir_assert.sv
`default_nettype none

module tag_dir_assert
  import tag_types_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input logic     req_valid,
  input logic     init_busy,
  input logic     rsp_valid,
  input tag_rsp_t rsp
);

  int unsigned fail_count = 0;

  // Accepted at edge k, response high between k+2 and k+3, so sampled at k+3
  a_rsp_latency: assert property (
    @(posedge clk) disable iff (rst)
    rsp_valid == $past(req_valid && !init_busy, 3)
  ) else begin
    $error("rsp_valid does not follow an accepted request at the fixed latency");
    fail_count++;
  end

  a_quiet_init: assert property (
    @(posedge clk) disable iff (rst)
    init_busy |-> !rsp_valid
  ) else begin
    $error("rsp_valid is high during the init sweep");
    fail_count++;
  end

  // An eviction only comes from a fill that missed
  a_evict_miss: assert property (
    @(posedge clk) disable iff (rst)
    (rsp_valid && rsp.evict_valid) |-> !rsp.hit
  ) else begin
    $error("Response reports an eviction together with a hit");
    fail_count++;
  end

endmodule

`default_nettype wire

//--- tag_dir_top.sv
`default_nettype none

module tag_dir_top
  import cache_geom_pkg::*;
  import tag_types_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     req_valid,
  input  tag_req_t req,
  output logic     rsp_valid,
  output tag_rsp_t rsp,
  output logic     init_busy
);

  logic                  accept;
  logic [index_bits-1:0] init_cnt;
  logic                  cmp_valid;
  tag_req_t              cmp_req;
  way_status_t           status0;
  way_status_t           status1;
  way_write_t            way_wr0;
  way_write_t            way_wr1;

  // Strobes during the sweep are dropped
  assign accept = req_valid && !init_busy;

  // ####################
  // Init sweep
  // ####################

  always_ff @(posedge clk) begin
    if (rst) begin
      init_busy <= 1'b1;
      init_cnt  <= '0;
    end else if (init_busy) begin
      init_cnt <= init_cnt + 1'b1;
      if (init_cnt == index_bits'(num_sets - 1)) begin
        init_busy <= 1'b0;
      end
    end
  end

  // Compare stage, same edge as the RAM read
  always_ff @(posedge clk) begin
    if (rst) begin
      cmp_valid <= 1'b0;
    end else begin
      cmp_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmp_req <= req;
    end
  end

  // ####################
  // Ways and resolution
  // ####################

  tag_way u_way0 (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (accept),
    .rd_addr (req.line_addr),
    .wr      (way_wr0),
    .status  (status0)
  );

  tag_way u_way1 (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (accept),
    .rd_addr (req.line_addr),
    .wr      (way_wr1),
    .status  (status1)
  );

  nru_victim u_nru (
    .clk        (clk),
    .rst        (rst),
    .cmp_valid  (cmp_valid),
    .cmp_req    (cmp_req),
    .rd_en      (accept),
    .rd_index   (req.line_addr[index_bits-1:0]),
    .init_clear (init_busy),
    .init_index (init_cnt),
    .status0    (status0),
    .status1    (status1),
    .way_wr0    (way_wr0),
    .way_wr1    (way_wr1),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp)
  );

endmodule

`default_nettype wire

//--- nru_victim.sv
`default_nettype none

module nru_victim
  import cache_geom_pkg::*;
  import tag_types_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cmp_valid,
  input  tag_req_t              cmp_req,
  input  logic                  rd_en,
  input  logic [index_bits-1:0] rd_index,
  input  logic                  init_clear,
  input  logic [index_bits-1:0] init_index,
  input  way_status_t           status0,
  input  way_status_t           status1,
  output way_write_t            way_wr0,
  output way_write_t            way_wr1,
  output logic                  rsp_valid,
  output tag_rsp_t              rsp
);

  typedef struct packed {
    logic                  en;
    logic [index_bits-1:0] index;
    nru_bits_t             bits;
  } nru_write_t;

  way_status_t           st [num_ways];
  way_write_t            wr_cmd [num_ways];
  logic [num_ways-1:0]   way_we;
  tag_entry_t            new_entry;
  logic [index_bits-1:0] cmp_index;
  logic [tag_bits-1:0]   cmp_tag;
  nru_bits_t             nru_ram_out;
  nru_bits_t             nru_cur;
  nru_bits_t             nru_next;
  nru_write_t            nru_wr_q;
  logic                  nru_upd;
  logic [way_bits-1:0]   upd_way;
  logic                  hit;
  logic [way_bits-1:0]   hit_way;
  logic [way_bits-1:0]   victim;
  tag_rsp_t              rsp_c;
  tag_rsp_t              rsp_mid;
  logic                  rsp_mid_valid;

  assign st[0]     = status0;
  assign st[1]     = status1;
  assign cmp_index = cmp_req.line_addr[index_bits-1:0];
  assign cmp_tag   = cmp_req.line_addr[addr_bits-1:index_bits];

  tag_ram #(
    .payload_t(nru_bits_t)
  ) u_nru_ram (
    .clk      (clk),
    .rst      (rst),
    .rd_en    (rd_en),
    .rd_index (rd_index),
    .rd_data  (nru_ram_out),
    .wr_en    (nru_wr_q.en),
    .wr_index (nru_wr_q.index),
    .wr_data  (nru_wr_q.bits)
  );

  // Own pending NRU write wins over the RAM for the same set
  assign nru_cur = (nru_wr_q.en && nru_wr_q.index == cmp_index) ? nru_wr_q.bits : nru_ram_out;

  // ####################
  // Hit and victim
  // ####################

  // Loops run downward so the lowest way is assigned last
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    victim  = '0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (st[w].match) begin
        hit     = 1'b1;
        hit_way = way_bits'(w);
      end
      if (!nru_cur[w]) begin
        victim = way_bits'(w);
      end
    end
    // An empty way beats any NRU choice
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (!st[w].valid) begin
        victim = way_bits'(w);
      end
    end
  end

  always_comb begin
    way_we    = '0;
    new_entry = '0;
    nru_upd   = 1'b0;
    upd_way   = hit_way;
    rsp_c     = '0;
    if (cmp_valid) begin
      rsp_c.hit = hit;
      rsp_c.way = hit_way;
      case (cmp_req.op)
        op_lookup: nru_upd = hit;
        op_fill: begin
          if (!hit) begin
            way_we[victim]    = 1'b1;
            new_entry.valid   = 1'b1;
            new_entry.tag     = cmp_tag;
            nru_upd           = 1'b1;
            upd_way           = victim;
            rsp_c.way         = victim;
            rsp_c.evict_valid = st[victim].valid;
            if (st[victim].valid) begin
              rsp_c.evict_addr = {st[victim].tag, cmp_index};
            end
          end
        end
        op_inval: way_we[hit_way] = hit;
        default: ;
      endcase
    end
  end

  // Set the used way, start a new round once every bit would be set
  always_comb begin
    nru_next          = nru_cur;
    nru_next[upd_way] = 1'b1;
    if (&nru_next) begin
      nru_next          = '0;
      nru_next[upd_way] = 1'b1;
    end
  end

  // ####################
  // Writes and response
  // ####################

  // Init sweep takes over both way write ports
  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      wr_cmd[w].en    = init_clear || way_we[w];
      wr_cmd[w].index = init_clear ? init_index : cmp_index;
      wr_cmd[w].entry = init_clear ? tag_entry_t'('0) : new_entry;
    end
  end

  assign way_wr0 = wr_cmd[0];
  assign way_wr1 = wr_cmd[1];

  always_ff @(posedge clk) begin
    if (rst) begin
      nru_wr_q.en   <= 1'b0;
      rsp_mid_valid <= 1'b0;
      rsp_valid     <= 1'b0;
    end else begin
      nru_wr_q.en   <= init_clear || nru_upd;
      rsp_mid_valid <= cmp_valid;
      rsp_valid     <= rsp_mid_valid;
    end
  end

  // Response leaves together with the state update it describes
  always_ff @(posedge clk) begin
    nru_wr_q.index <= init_clear ? init_index : cmp_index;
    nru_wr_q.bits  <= init_clear ? nru_bits_t'('0) : nru_next;
    rsp_mid        <= rsp_c;
    rsp            <= rsp_mid;
  end

endmodule

`default_nettype wire

//--- tag_way.sv
`default_nettype none

module tag_way
  import cache_geom_pkg::*;
  import tag_types_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rd_en,
  input  logic [addr_bits-1:0] rd_addr,
  input  way_write_t           wr,
  output way_status_t          status
);

  tag_entry_t            ram_data;
  tag_entry_t            entry;
  way_write_t            wr_q;
  logic [addr_bits-1:0]  addr_q;
  logic [index_bits-1:0] addr_index;
  logic [tag_bits-1:0]   addr_tag;
  logic                  fwd_hit;

  // ####################
  // Storage
  // ####################

  tag_ram #(
    .payload_t(tag_entry_t)
  ) u_ram (
    .clk      (clk),
    .rst      (rst),
    .rd_en    (rd_en),
    .rd_index (rd_addr[index_bits-1:0]),
    .rd_data  (ram_data),
    .wr_en    (wr_q.en),
    .wr_index (wr_q.index),
    .wr_data  (wr_q.entry)
  );

  // Write command from the compare stage lands in the RAM one edge later
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_q.en <= 1'b0;
    end else begin
      wr_q.en <= wr.en;
    end
  end

  always_ff @(posedge clk) begin
    wr_q.index <= wr.index;
    wr_q.entry <= wr.entry;
  end

  // Address of the request now being read, held for the compare
  always_ff @(posedge clk) begin
    if (rd_en) begin
      addr_q <= rd_addr;
    end
  end

  assign addr_index = addr_q[index_bits-1:0];
  assign addr_tag   = addr_q[addr_bits-1:index_bits];

  // ####################
  // Forward and compare
  // ####################

  // Pending write to the same set is newer than the RAM contents
  assign fwd_hit = wr_q.en && (wr_q.index == addr_index);
  assign entry   = fwd_hit ? wr_q.entry : ram_data;

  always_comb begin
    status.valid = entry.valid;
    status.match = entry.valid && (entry.tag == addr_tag);
    status.tag   = entry.tag;
  end

endmodule

`default_nettype wire

//--- tag_ram.sv
`default_nettype none

module tag_ram
  import cache_geom_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rd_en,
  input  logic [index_bits-1:0] rd_index,
  output payload_t              rd_data,
  input  logic                  wr_en,
  input  logic [index_bits-1:0] wr_index,
  input  payload_t              wr_data
);

  payload_t              mem [num_sets];
  logic [index_bits-1:0] rd_index_q;

  // Read address is latched, data follows it combinationally
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_index_q <= '0;
    end else if (rd_en) begin
      rd_index_q <= rd_index;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_index] <= wr_data;
    end
  end

  // A write at the same edge is already visible here
  assign rd_data = mem[rd_index_q];

endmodule

`default_nettype wire

//--- tag_types_pkg.sv
`default_nettype none

package tag_types_pkg;
  import cache_geom_pkg::*;

  typedef enum logic [1:0] {
    op_lookup = 2'd0,
    op_fill   = 2'd1,
    op_inval  = 2'd2
  } tag_op_e;

  typedef struct packed {
    tag_op_e              op;
    logic [addr_bits-1:0] line_addr;
  } tag_req_t;

  // One entry of a tag way
  typedef struct packed {
    logic                valid;
    logic [tag_bits-1:0] tag;
  } tag_entry_t;

  // Referenced bit per way, bit n belongs to way n
  typedef logic [num_ways-1:0] nru_bits_t;

  // What one way reports for the request in the compare stage
  typedef struct packed {
    logic                valid;
    logic                match;
    logic [tag_bits-1:0] tag;
  } way_status_t;

  typedef struct packed {
    logic                  en;
    logic [index_bits-1:0] index;
    tag_entry_t            entry;
  } way_write_t;

  typedef struct packed {
    logic                 hit;
    logic [way_bits-1:0]  way;
    logic                 evict_valid;
    logic [addr_bits-1:0] evict_addr;
  } tag_rsp_t;

endpackage

`default_nettype wire

//--- cache_geom_pkg.sv
`default_nettype none

// ####################
// Directory geometry
// ####################

package cache_geom_pkg;

  // Sets per way, one init sweep step each
  localparam int num_sets = 64;

  // Set index taken from the low line address bits
  localparam int index_bits = 6;

  // Line address width of a request
  localparam int addr_bits = 20;

  // Upper line address bits kept per entry
  localparam int tag_bits = addr_bits - index_bits;

  localparam int num_ways = 2;
  localparam int way_bits = $clog2(num_ways);

endpackage

`default_nettype wire
